/* common/fabric_pkg.sv */
package fabric_pkg;

    // ########################################
    // widths and basic types
    // ########################################

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;

    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2; // subordinate timeout
    localparam resp_t resp_decerr = 2'd3; // unmapped address

    // ########################################
    // address map
    // ########################################

    typedef logic [1:0] sub_idx_t;

    localparam sub_idx_t sub_mem   = 2'd0;
    localparam sub_idx_t sub_hsip  = 2'd1;
    localparam sub_idx_t sub_lsdom = 2'd2;

    localparam int num_subs = 3;

    // end addresses are exclusive
    localparam addr_t mem_base   = 32'h0000_0000;
    localparam addr_t mem_end    = 32'h0008_0000;
    localparam addr_t hsip_base  = 32'h0009_0000;
    localparam addr_t hsip_end   = 32'h0009_0400;
    localparam addr_t lsdom_base = 32'h0100_0000;
    localparam addr_t lsdom_end  = 32'h0200_0000;

    // ########################################
    // watchdog
    // ########################################

    localparam int resp_timeout = 16; // cycles
    localparam int timer_w      = $clog2(resp_timeout);

endpackage

/* common/bus_if.sv */
`timescale 1ns/100ps

interface bus_if;
    import fabric_pkg::*;

    logic  req_valid;
    logic  req_ready;
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;
    strb_t req_strb;

    logic  rsp_valid;
    logic  rsp_ready;
    data_t rsp_rdata; // zero on writes and errors
    resp_t rsp_resp;

    modport manager (
        output req_valid, req_write, req_addr, req_wdata, req_strb,
        input  req_ready,
        input  rsp_valid, rsp_rdata, rsp_resp,
        output rsp_ready
    );

    modport subordinate (
        input  req_valid, req_write, req_addr, req_wdata, req_strb,
        output req_ready,
        output rsp_valid, rsp_rdata, rsp_resp,
        input  rsp_ready
    );

endinterface

/* hw/fabric_arbiter.sv */
`timescale 1ns/100ps

module fabric_arbiter (
    input  logic       clk,
    input  logic       rst_n,
    bus_if.subordinate cpu,
    bus_if.subordinate dma,
    bus_if.manager     shared
);

    logic busy;     // winner locked
    logic owner;    // 0 cpu, 1 dma
    logic last_q;   // manager served last
    logic pick;
    logic sel;
    logic rsp_done;

    // both valid -> the one not served last
    assign pick = (cpu.req_valid && dma.req_valid) ? ~last_q : dma.req_valid;
    assign sel  = busy ? owner : pick;

    assign rsp_done = shared.rsp_valid && shared.rsp_ready;

    // ########################################
    // request steering
    // ########################################

    assign shared.req_valid = sel ? dma.req_valid : cpu.req_valid;
    assign shared.req_write = sel ? dma.req_write : cpu.req_write;
    assign shared.req_addr  = sel ? dma.req_addr  : cpu.req_addr;
    assign shared.req_wdata = sel ? dma.req_wdata : cpu.req_wdata;
    assign shared.req_strb  = sel ? dma.req_strb  : cpu.req_strb;

    assign cpu.req_ready = !sel && shared.req_ready;
    assign dma.req_ready = sel && shared.req_ready;

    // ########################################
    // response return
    // ########################################

    assign cpu.rsp_valid = busy && !owner && shared.rsp_valid;
    assign dma.rsp_valid = busy && owner && shared.rsp_valid;
    assign cpu.rsp_rdata = shared.rsp_rdata;
    assign dma.rsp_rdata = shared.rsp_rdata;
    assign cpu.rsp_resp  = shared.rsp_resp;
    assign dma.rsp_resp  = shared.rsp_resp;

    assign shared.rsp_ready = busy && (owner ? dma.rsp_ready : cpu.rsp_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            owner  <= 1'b0;
            last_q <= 1'b1; // cpu goes first
        end else if (!busy) begin
            if (cpu.req_valid || dma.req_valid) begin
                busy  <= 1'b1;
                owner <= pick;
            end
        end else if (rsp_done) begin
            busy   <= 1'b0;
            last_q <= owner;
        end
    end

endmodule

/* hw/addr_decoder.sv */
`timescale 1ns/100ps

module addr_decoder (
    input  fabric_pkg::addr_t    addr,
    output logic                 hit,
    output fabric_pkg::sub_idx_t idx,
    output fabric_pkg::addr_t    offset
);
    import fabric_pkg::*;

    logic in_mem;
    logic in_hsip;
    logic in_lsdom;

    assign in_mem   = (addr >= mem_base) && (addr < mem_end);
    assign in_hsip  = (addr >= hsip_base) && (addr < hsip_end);
    assign in_lsdom = (addr >= lsdom_base) && (addr < lsdom_end);

    always_comb begin
        hit    = 1'b1;
        idx    = sub_mem;
        offset = '0;
        if (in_mem) begin
            idx    = sub_mem;
            offset = addr - mem_base;
        end else if (in_hsip) begin
            idx    = sub_hsip;
            offset = addr - hsip_base;
        end else if (in_lsdom) begin
            idx    = sub_lsdom;
            offset = addr - lsdom_base;
        end else begin
            hit = 1'b0; // outside the map
        end
    end

endmodule

/* fabric_ctrl/resp_timer.sv */
`timescale 1ns/100ps

module resp_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic expired
);
    import fabric_pkg::*;

    logic [timer_w-1:0] count;

    // high on the resp_timeout-th cycle of run
    assign expired = run && (count == timer_w'(resp_timeout - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

endmodule

/* fabric_ctrl/fabric_ctrl.sv */
`timescale 1ns/100ps

module fabric_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pause_req,
    output logic       pause_ack,
    bus_if.subordinate shared,
    bus_if.manager     subs [fabric_pkg::num_subs]
);
    import fabric_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_issue,
        st_wait_rsp,
        st_respond,
        st_paused
    } state_t;

    state_t   state;
    logic     ready_q;
    logic     accept;
    logic     timeout;

    logic     dec_hit;
    sub_idx_t dec_idx;
    addr_t    dec_offset;

    logic     wr_q;
    addr_t    offset_q;
    data_t    wdata_q;
    strb_t    strb_q;
    sub_idx_t idx_q;
    data_t    rdata_q;
    resp_t    resp_q;

    logic     timer_run;
    logic     timer_expired;

    logic [num_subs-1:0] sub_req_ready;
    logic [num_subs-1:0] sub_rsp_valid;
    data_t               sub_rdata [num_subs];
    resp_t               sub_resp  [num_subs];
    logic                sel_req_ready;
    logic                sel_rsp_valid;

    assign shared.req_ready = ready_q && !pause_req;
    assign accept           = shared.req_valid && shared.req_ready;

    addr_decoder u_addr_decoder (
        .addr   (shared.req_addr),
        .hit    (dec_hit),
        .idx    (dec_idx),
        .offset (dec_offset)
    );

    assign timer_run = (state == st_issue) || (state == st_wait_rsp);

    resp_timer u_resp_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (timer_run),
        .expired (timer_expired)
    );

    // ########################################
    // subordinate side
    // ########################################

    for (genvar i = 0; i < num_subs; i++) begin : g_sub
        assign subs[i].req_valid = (state == st_issue) && (idx_q == sub_idx_t'(i));
        assign subs[i].req_write = wr_q;
        assign subs[i].req_addr  = offset_q; // region relative
        assign subs[i].req_wdata = wdata_q;
        assign subs[i].req_strb  = strb_q;
        assign subs[i].rsp_ready = (state == st_wait_rsp) && (idx_q == sub_idx_t'(i));

        assign sub_req_ready[i] = subs[i].req_ready;
        assign sub_rsp_valid[i] = subs[i].rsp_valid;
        assign sub_rdata[i]     = subs[i].rsp_rdata;
        assign sub_resp[i]      = subs[i].rsp_resp;
    end

    assign sel_req_ready = sub_req_ready[idx_q];
    assign sel_rsp_valid = sub_rsp_valid[idx_q];

    // handshake wins over a same-cycle expiry
    assign timeout = timer_expired &&
                     (((state == st_issue) && !sel_req_ready) ||
                      ((state == st_wait_rsp) && !sel_rsp_valid));

    // ########################################
    // manager side
    // ########################################

    assign shared.rsp_valid = (state == st_respond);
    assign shared.rsp_rdata = rdata_q;
    assign shared.rsp_resp  = resp_q;

    assign pause_ack = (state == st_paused);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (pause_req) begin
                        state <= st_paused;
                    end else if (accept) begin
                        state <= dec_hit ? st_issue : st_respond;
                    end else begin
                        ready_q <= shared.req_valid;
                    end
                end
                st_issue: begin
                    if (sel_req_ready) begin
                        state <= st_wait_rsp;
                    end else if (timeout) begin
                        state <= st_respond; // request dropped
                    end
                end
                st_wait_rsp: begin
                    if (sel_rsp_valid || timeout) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    if (shared.rsp_ready) begin
                        state <= st_idle;
                    end
                end
                st_paused: begin
                    if (!pause_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_q     <= shared.req_write;
            offset_q <= dec_offset;
            wdata_q  <= shared.req_wdata;
            strb_q   <= shared.req_strb;
            idx_q    <= dec_idx;
        end
        if (accept && !dec_hit) begin
            rdata_q <= '0;
            resp_q  <= resp_decerr;
        end else if (timeout) begin
            rdata_q <= '0;
            resp_q  <= resp_slverr;
        end else if ((state == st_wait_rsp) && sel_rsp_valid) begin
            rdata_q <= sub_rdata[idx_q];
            resp_q  <= sub_resp[idx_q];
        end
    end

endmodule

/* hw/hsdom_fabric.sv */
`timescale 1ns/100ps

module hsdom_fabric (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pause_req,
    output logic              pause_ack,

    input  logic              cpu_req_valid,
    output logic              cpu_req_ready,
    input  logic              cpu_req_write,
    input  fabric_pkg::addr_t cpu_req_addr,
    input  fabric_pkg::data_t cpu_req_wdata,
    input  fabric_pkg::strb_t cpu_req_strb,
    output logic              cpu_rsp_valid,
    input  logic              cpu_rsp_ready,
    output fabric_pkg::data_t cpu_rsp_rdata,
    output fabric_pkg::resp_t cpu_rsp_resp,

    input  logic              dma_req_valid,
    output logic              dma_req_ready,
    input  logic              dma_req_write,
    input  fabric_pkg::addr_t dma_req_addr,
    input  fabric_pkg::data_t dma_req_wdata,
    input  fabric_pkg::strb_t dma_req_strb,
    output logic              dma_rsp_valid,
    input  logic              dma_rsp_ready,
    output fabric_pkg::data_t dma_rsp_rdata,
    output fabric_pkg::resp_t dma_rsp_resp,

    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output logic              mem_req_write,
    output fabric_pkg::addr_t mem_req_addr,
    output fabric_pkg::data_t mem_req_wdata,
    output fabric_pkg::strb_t mem_req_strb,
    input  logic              mem_rsp_valid,
    output logic              mem_rsp_ready,
    input  fabric_pkg::data_t mem_rsp_rdata,
    input  fabric_pkg::resp_t mem_rsp_resp,

    output logic              hsip_req_valid,
    input  logic              hsip_req_ready,
    output logic              hsip_req_write,
    output fabric_pkg::addr_t hsip_req_addr,
    output fabric_pkg::data_t hsip_req_wdata,
    output fabric_pkg::strb_t hsip_req_strb,
    input  logic              hsip_rsp_valid,
    output logic              hsip_rsp_ready,
    input  fabric_pkg::data_t hsip_rsp_rdata,
    input  fabric_pkg::resp_t hsip_rsp_resp,

    output logic              lsdom_req_valid,
    input  logic              lsdom_req_ready,
    output logic              lsdom_req_write,
    output fabric_pkg::addr_t lsdom_req_addr,
    output fabric_pkg::data_t lsdom_req_wdata,
    output fabric_pkg::strb_t lsdom_req_strb,
    input  logic              lsdom_rsp_valid,
    output logic              lsdom_rsp_ready,
    input  fabric_pkg::data_t lsdom_rsp_rdata,
    input  fabric_pkg::resp_t lsdom_rsp_resp
);
    import fabric_pkg::*;

    bus_if cpu_bus ();
    bus_if dma_bus ();
    bus_if shared_bus ();
    bus_if sub_bus [num_subs] ();

    // ########################################
    // manager ports
    // ########################################

    assign cpu_bus.req_valid = cpu_req_valid;
    assign cpu_bus.req_write = cpu_req_write;
    assign cpu_bus.req_addr  = cpu_req_addr;
    assign cpu_bus.req_wdata = cpu_req_wdata;
    assign cpu_bus.req_strb  = cpu_req_strb;
    assign cpu_bus.rsp_ready = cpu_rsp_ready;
    assign cpu_req_ready     = cpu_bus.req_ready;
    assign cpu_rsp_valid     = cpu_bus.rsp_valid;
    assign cpu_rsp_rdata     = cpu_bus.rsp_rdata;
    assign cpu_rsp_resp      = cpu_bus.rsp_resp;

    assign dma_bus.req_valid = dma_req_valid;
    assign dma_bus.req_write = dma_req_write;
    assign dma_bus.req_addr  = dma_req_addr;
    assign dma_bus.req_wdata = dma_req_wdata;
    assign dma_bus.req_strb  = dma_req_strb;
    assign dma_bus.rsp_ready = dma_rsp_ready;
    assign dma_req_ready     = dma_bus.req_ready;
    assign dma_rsp_valid     = dma_bus.rsp_valid;
    assign dma_rsp_rdata     = dma_bus.rsp_rdata;
    assign dma_rsp_resp      = dma_bus.rsp_resp;

    // ########################################
    // subordinate ports
    // ########################################

    assign mem_req_valid                = sub_bus[sub_mem].req_valid;
    assign mem_req_write                = sub_bus[sub_mem].req_write;
    assign mem_req_addr                 = sub_bus[sub_mem].req_addr;
    assign mem_req_wdata                = sub_bus[sub_mem].req_wdata;
    assign mem_req_strb                 = sub_bus[sub_mem].req_strb;
    assign mem_rsp_ready                = sub_bus[sub_mem].rsp_ready;
    assign sub_bus[sub_mem].req_ready   = mem_req_ready;
    assign sub_bus[sub_mem].rsp_valid   = mem_rsp_valid;
    assign sub_bus[sub_mem].rsp_rdata   = mem_rsp_rdata;
    assign sub_bus[sub_mem].rsp_resp    = mem_rsp_resp;

    assign hsip_req_valid               = sub_bus[sub_hsip].req_valid;
    assign hsip_req_write               = sub_bus[sub_hsip].req_write;
    assign hsip_req_addr                = sub_bus[sub_hsip].req_addr;
    assign hsip_req_wdata               = sub_bus[sub_hsip].req_wdata;
    assign hsip_req_strb                = sub_bus[sub_hsip].req_strb;
    assign hsip_rsp_ready               = sub_bus[sub_hsip].rsp_ready;
    assign sub_bus[sub_hsip].req_ready  = hsip_req_ready;
    assign sub_bus[sub_hsip].rsp_valid  = hsip_rsp_valid;
    assign sub_bus[sub_hsip].rsp_rdata  = hsip_rsp_rdata;
    assign sub_bus[sub_hsip].rsp_resp   = hsip_rsp_resp;

    assign lsdom_req_valid              = sub_bus[sub_lsdom].req_valid;
    assign lsdom_req_write              = sub_bus[sub_lsdom].req_write;
    assign lsdom_req_addr               = sub_bus[sub_lsdom].req_addr;
    assign lsdom_req_wdata              = sub_bus[sub_lsdom].req_wdata;
    assign lsdom_req_strb               = sub_bus[sub_lsdom].req_strb;
    assign lsdom_rsp_ready              = sub_bus[sub_lsdom].rsp_ready;
    assign sub_bus[sub_lsdom].req_ready = lsdom_req_ready;
    assign sub_bus[sub_lsdom].rsp_valid = lsdom_rsp_valid;
    assign sub_bus[sub_lsdom].rsp_rdata = lsdom_rsp_rdata;
    assign sub_bus[sub_lsdom].rsp_resp  = lsdom_rsp_resp;

    fabric_arbiter u_fabric_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu    (cpu_bus),
        .dma    (dma_bus),
        .shared (shared_bus)
    );

    fabric_ctrl u_fabric_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .shared    (shared_bus),
        .subs      (sub_bus)
    );

endmodule

/* testbench/sub_model.sv */
`timescale 1ns/100ps

module sub_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,      // hold off acceptance
    input  logic              mute,       // never accept, so never answer
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_write,
    input  fabric_pkg::addr_t req_addr,
    input  fabric_pkg::data_t req_wdata,
    input  fabric_pkg::strb_t req_strb,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output fabric_pkg::data_t rsp_rdata,
    output fabric_pkg::resp_t rsp_resp,
    output logic [15:0]       seen,       // accepted requests
    output fabric_pkg::addr_t last_addr
);
    import fabric_pkg::*;

    data_t mem [256];
    logic  pending;

    function automatic data_t merge(input data_t old, input data_t wdata, input strb_t strb);
        data_t w;
        w = old;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    assign req_ready = !stall && !mute && !pending;
    assign rsp_valid = pending; // one cycle after acceptance
    assign rsp_resp  = resp_okay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            rsp_rdata <= '0;
            seen      <= '0;
            last_addr <= '0;
        end else if (req_valid && req_ready) begin
            pending   <= 1'b1;
            seen      <= seen + 1'b1;
            last_addr <= req_addr;
            rsp_rdata <= req_write ? '0 : mem[req_addr[9:2]];
            if (req_write) begin
                mem[req_addr[9:2]] <= merge(mem[req_addr[9:2]], req_wdata, req_strb);
            end
        end else if (rsp_valid && rsp_ready) begin
            pending <= 1'b0;
        end
    end

endmodule

/* testbench/hsdom_fabric_tb.sv */
`timescale 1ns/100ps

module hsdom_fabric_tb;
    import fabric_pkg::*;

    localparam int          clk_period  = 4;
    localparam int          cycle_limit = 2000; // six tests of a few hundred cycles with margin
    localparam logic [31:0] lfsr_seed   = 32'hd8b6_2059;

    logic  clk;
    logic  rst_n;
    logic  pause_req, pause_ack;
    logic  cpu_req_valid, cpu_req_ready, cpu_req_write, cpu_rsp_valid, cpu_rsp_ready;
    logic  dma_req_valid, dma_req_ready, dma_req_write, dma_rsp_valid, dma_rsp_ready;
    logic  mem_req_valid, mem_req_ready, mem_req_write, mem_rsp_valid, mem_rsp_ready;
    logic  hsip_req_valid, hsip_req_ready, hsip_req_write, hsip_rsp_valid, hsip_rsp_ready;
    logic  lsdom_req_valid, lsdom_req_ready, lsdom_req_write, lsdom_rsp_valid, lsdom_rsp_ready;
    addr_t cpu_req_addr, dma_req_addr, mem_req_addr, hsip_req_addr, lsdom_req_addr;
    data_t cpu_req_wdata, dma_req_wdata, mem_req_wdata, hsip_req_wdata, lsdom_req_wdata;
    data_t cpu_rsp_rdata, dma_rsp_rdata, mem_rsp_rdata, hsip_rsp_rdata, lsdom_rsp_rdata;
    strb_t cpu_req_strb, dma_req_strb, mem_req_strb, hsip_req_strb, lsdom_req_strb;
    resp_t cpu_rsp_resp, dma_rsp_resp, mem_rsp_resp, hsip_rsp_resp, lsdom_rsp_resp;

    logic [2:0]       stall;
    logic [2:0]       mute;
    logic [2:0][15:0] seen;
    logic [2:0][31:0] last_addr;
    logic [31:0]      lfsr;
    int               errors;
    int               checks;
    int               cycle_count;
    bit               served [$]; // accepted manager, 1 = dma
    addr_t            base [3];
    addr_t            top  [3];   // exclusive
    data_t            stored [3][2];

    hsdom_fabric u_hsdom_fabric (.*);

    // ports in declaration order of sub_model
    sub_model u_mem_model (
        clk, rst_n, stall[sub_mem], mute[sub_mem], mem_req_valid, mem_req_ready,
        mem_req_write, mem_req_addr, mem_req_wdata, mem_req_strb, mem_rsp_valid,
        mem_rsp_ready, mem_rsp_rdata, mem_rsp_resp, seen[sub_mem], last_addr[sub_mem]
    );
    sub_model u_hsip_model (
        clk, rst_n, stall[sub_hsip], mute[sub_hsip], hsip_req_valid, hsip_req_ready,
        hsip_req_write, hsip_req_addr, hsip_req_wdata, hsip_req_strb, hsip_rsp_valid,
        hsip_rsp_ready, hsip_rsp_rdata, hsip_rsp_resp, seen[sub_hsip], last_addr[sub_hsip]
    );
    sub_model u_lsdom_model (
        clk, rst_n, stall[sub_lsdom], mute[sub_lsdom], lsdom_req_valid, lsdom_req_ready,
        lsdom_req_write, lsdom_req_addr, lsdom_req_wdata, lsdom_req_strb, lsdom_rsp_valid,
        lsdom_rsp_ready, lsdom_rsp_rdata, lsdom_rsp_resp, seen[sub_lsdom], last_addr[sub_lsdom]
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // ########################################
    // stimulus helpers and compares
    // ########################################

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic data_t rand_word();
        data_t w;
        w = '0;
        for (int i = 0; i < data_w; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[data_w-2:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%-18s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic drive_req(input bit dma, input logic valid, input logic wr,
                             input addr_t addr, input data_t wdata);
        if (dma) begin
            dma_req_valid = valid;
            dma_req_write = wr;
            dma_req_addr  = addr;
            dma_req_wdata = wdata;
        end else begin
            cpu_req_valid = valid;
            cpu_req_write = wr;
            cpu_req_addr  = addr;
            cpu_req_wdata = wdata;
        end
    endtask

    // returns on the falling edge after the request transfer
    task automatic send_req(input bit dma, input logic wr, input addr_t addr, input data_t wdata);
        logic ready;
        @(negedge clk);
        drive_req(dma, 1'b1, wr, addr, wdata);
        #1;
        ready = dma ? dma_req_ready : cpu_req_ready;
        while (!ready) begin
            @(negedge clk);
            #1;
            ready = dma ? dma_req_ready : cpu_req_ready;
        end
        served.push_back(dma);
        @(negedge clk);
        drive_req(dma, 1'b0, 1'b0, '0, '0);
    endtask

    // called on a falling edge and samples mid-cycle
    task automatic wait_rsp(input bit dma, output data_t rdata, output resp_t resp);
        logic valid;
        #1;
        valid = dma ? dma_rsp_valid : cpu_rsp_valid;
        while (!valid) begin
            @(negedge clk);
            #1;
            valid = dma ? dma_rsp_valid : cpu_rsp_valid;
        end
        rdata = dma ? dma_rsp_rdata : cpu_rsp_rdata;
        resp  = dma ? dma_rsp_resp : cpu_rsp_resp;
    endtask

    task automatic issue(input bit dma, input logic wr, input addr_t addr, input data_t wdata,
                         output data_t rdata, output resp_t resp);
        send_req(dma, wr, addr, wdata);
        wait_rsp(dma, rdata, resp);
    endtask

    task automatic wait_pause_ack(input logic level);
        @(negedge clk);
        #1;
        while (pause_ack !== level) begin
            @(negedge clk);
            #1;
        end
    endtask

    // ########################################
    // directed tests
    // ########################################

    task map_and_data_path;
        int    errs;
        addr_t addr;
        data_t rdata;
        resp_t resp;
        errs = errors;
        for (int rd = 0; rd < 2; rd++) begin
            for (int r = 0; r < num_subs; r++) begin
                for (int k = 0; k < 2; k++) begin
                    addr = k ? top[r] - 4 : base[r];
                    if (!rd) begin
                        stored[r][k] = rand_word();
                    end
                    issue(1'b0, !rd, addr, stored[r][k], rdata, resp);
                    check_data("cpu_rsp_rdata", rdata, rd ? stored[r][k] : '0);
                    check_resp("cpu_rsp_resp", resp, resp_okay);
                    check_addr("sub req_addr", last_addr[r], addr - base[r]);
                end
            end
        end
        report_test("map_and_data_path", errs);
    endtask

    task decode_error;
        int               errs;
        logic [2:0][15:0] seen_before;
        data_t            rdata;
        resp_t            resp;
        errs        = errors;
        seen_before = seen;
        issue(1'b0, 1'b0, mem_end, '0, rdata, resp); // gap below hsip
        check_resp("cpu_rsp_resp", resp, resp_decerr);
        check_data("cpu_rsp_rdata", rdata, '0);
        issue(1'b0, 1'b1, lsdom_end, rand_word(), rdata, resp);
        check_resp("cpu_rsp_resp", resp, resp_decerr);
        check_data("cpu_rsp_rdata", rdata, '0);
        check_flag("subordinate saw request", seen != seen_before, 1'b0);
        report_test("decode_error", errs);
    endtask

    task round_robin;
        int    errs;
        bit    first;
        data_t rdata [2][2];
        resp_t resp  [2][2];
        errs  = errors;
        first = !served[$];
        served.delete();
        fork
            begin
                issue(1'b0, 1'b0, mem_base, '0, rdata[0][0], resp[0][0]);
                issue(1'b0, 1'b0, mem_end - 4, '0, rdata[0][1], resp[0][1]);
            end
            begin
                issue(1'b1, 1'b0, lsdom_base, '0, rdata[1][0], resp[1][0]);
                issue(1'b1, 1'b0, lsdom_end - 4, '0, rdata[1][1], resp[1][1]);
            end
        join
        for (int i = 0; i < 4; i++) begin
            check_flag("served dma", served[i], first ^ i[0]);
        end
        for (int m = 0; m < 2; m++) begin
            for (int k = 0; k < 2; k++) begin
                check_data("rsp_rdata", rdata[m][k], stored[m ? sub_lsdom : sub_mem][k]);
                check_resp("rsp_resp", resp[m][k], resp_okay);
            end
        end
        report_test("round_robin", errs);
    endtask

    task back_pressure;
        int    errs;
        data_t held;
        data_t rdata;
        resp_t resp;
        errs = errors;
        @(negedge clk);
        stall[sub_mem] = 1'b1;
        cpu_rsp_ready  = 1'b0;
        send_req(1'b0, 1'b0, mem_base, '0);
        repeat (5) @(negedge clk);
        stall[sub_mem] = 1'b0;
        wait_rsp(1'b0, held, resp);
        check_data("cpu_rsp_rdata", held, stored[sub_mem][0]);
        @(negedge clk);
        drive_req(1'b1, 1'b1, 1'b0, lsdom_base, '0);
        repeat (4) begin
            @(negedge clk);
            #1;
            check_flag("cpu_rsp_valid", cpu_rsp_valid, 1'b1);
            check_data("cpu_rsp_rdata", cpu_rsp_rdata, held);
            check_resp("cpu_rsp_resp", cpu_rsp_resp, resp_okay);
            check_flag("dma_req_ready", dma_req_ready, 1'b0);
        end
        @(negedge clk);
        cpu_rsp_ready = 1'b1;
        issue(1'b1, 1'b0, lsdom_base, '0, rdata, resp);
        check_data("dma_rsp_rdata", rdata, stored[sub_lsdom][0]);
        check_resp("dma_rsp_resp", resp, resp_okay);
        report_test("back_pressure", errs);
    endtask

    task watchdog_timeout;
        int    errs;
        data_t rdata;
        resp_t resp;
        errs = errors;
        @(negedge clk);
        mute[sub_hsip] = 1'b1;
        issue(1'b0, 1'b0, hsip_base, '0, rdata, resp);
        check_resp("cpu_rsp_resp", resp, resp_slverr);
        check_data("cpu_rsp_rdata", rdata, '0);
        @(negedge clk);
        mute[sub_hsip] = 1'b0;
        issue(1'b0, 1'b0, mem_end - 4, '0, rdata, resp);
        check_resp("cpu_rsp_resp", resp, resp_okay);
        check_data("cpu_rsp_rdata", rdata, stored[sub_mem][1]);
        report_test("watchdog_timeout", errs);
    endtask

    task pause_drain;
        int    errs;
        data_t rdata;
        resp_t resp;
        errs = errors;
        @(negedge clk);
        stall[sub_mem] = 1'b1;
        send_req(1'b0, 1'b0, mem_base, '0);
        pause_req = 1'b1; // transaction still in flight
        repeat (3) begin
            @(negedge clk);
            #1;
            check_flag("pause_ack", pause_ack, 1'b0);
        end
        @(negedge clk);
        stall[sub_mem] = 1'b0;
        wait_rsp(1'b0, rdata, resp);
        check_flag("pause_ack", pause_ack, 1'b0);
        check_data("cpu_rsp_rdata", rdata, stored[sub_mem][0]);
        check_resp("cpu_rsp_resp", resp, resp_okay);
        wait_pause_ack(1'b1);
        @(negedge clk);
        drive_req(1'b1, 1'b1, 1'b0, lsdom_end - 4, '0);
        repeat (4) begin
            @(negedge clk);
            #1;
            check_flag("dma_req_ready", dma_req_ready, 1'b0);
            check_flag("pause_ack", pause_ack, 1'b1);
        end
        @(negedge clk);
        pause_req = 1'b0;
        wait_pause_ack(1'b0);
        issue(1'b1, 1'b0, lsdom_end - 4, '0, rdata, resp);
        check_data("dma_rsp_rdata", rdata, stored[sub_lsdom][1]);
        check_resp("dma_rsp_resp", resp, resp_okay);
        report_test("pause_drain", errs);
    endtask

    // ########################################
    // main sequence and watchdog
    // ########################################

    initial begin
        lfsr   = lfsr_seed;
        errors = 0;
        checks = 0;
        base   = '{mem_base, hsip_base, lsdom_base};
        top    = '{mem_end, hsip_end, lsdom_end};
        rst_n         = 1'b0;
        pause_req     = 1'b0;
        stall         = '0;
        mute          = '0;
        cpu_req_strb  = '1;
        dma_req_strb  = '1;
        cpu_rsp_ready = 1'b1;
        dma_rsp_ready = 1'b1;
        drive_req(1'b0, 1'b0, 1'b0, '0, '0);
        drive_req(1'b1, 1'b0, 1'b0, '0, '0);
        repeat (3) @(negedge clk);
        check_flag("outputs idle in reset",
                   |{cpu_req_ready, dma_req_ready, cpu_rsp_valid, dma_rsp_valid,
                     mem_req_valid, hsip_req_valid, lsdom_req_valid, pause_ack}, 1'b0);
        rst_n = 1'b1;
        map_and_data_path;
        decode_error;
        round_robin;
        back_pressure;
        watchdog_timeout;
        pause_drain;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
    end

endmodule

/* hsdom_fabric.f */
common/fabric_pkg.sv
common/bus_if.sv
hw/fabric_arbiter.sv
hw/addr_decoder.sv
fabric_ctrl/resp_timer.sv
fabric_ctrl/fabric_ctrl.sv
hw/hsdom_fabric.sv
testbench/sub_model.sv
testbench/hsdom_fabric_tb.sv
